// File: rtl/compute_pkg.sv
package compute_pkg;

    // stream widths
    localparam int data_width = 64;
    localparam int dest_width = 3;

    // descriptor word layout
    localparam int time_of   = 0;
    localparam int time_size = 16;

    // service chain, item 0 sits in the low bits
    localparam int chain_of    = 16;
    localparam int chain_items = 4;
    localparam int chain_size  = chain_items * dest_width;

    localparam int port_of = 28;

    // packet tag, not used by the data path
    localparam int tag_of   = 32;
    localparam int tag_size = 8;

    // fixed destinations
    localparam logic [dest_width-1:0] detour_dest_0 = 3'd0;
    localparam logic [dest_width-1:0] detour_dest_1 = 3'd3;
    localparam logic [dest_width-1:0] dma_dest      = 3'd1;

    typedef enum logic [1:0] {
        steer_idle,
        steer_insert,
        steer_detour
    } steer_state_t;

    typedef enum logic [1:0] {
        comp_idle,
        comp_busy,
        comp_head,
        comp_data
    } compute_state_t;

endpackage

// File: rtl/pkt_if.sv
`timescale 1ns/1ps

interface pkt_if #(
    parameter int data_width = compute_pkg::data_width
);

    logic [data_width-1:0]              data;
    logic                               valid;
    logic                               ready;
    logic                               last;
    logic [compute_pkg::dest_width-1:0] dest;

    // word moves when valid and ready are both high
    modport src (
        output data, valid, last, dest,
        input  ready
    );

    modport snk (
        input  data, valid, last, dest,
        output ready
    );

endinterface

// File: rtl/pkt_fifo.sv
`timescale 1ns/1ps

module pkt_fifo #(
    parameter int width = compute_pkg::data_width,
    parameter int depth = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [width-1:0]                   wr_data,
    input  logic                               wr_valid,
    output logic                               wr_ready,
    input  logic                               wr_last,
    input  logic [compute_pkg::dest_width-1:0] wr_dest,
    output logic [width-1:0]                   rd_data,
    output logic                               rd_valid,
    input  logic                               rd_ready,
    output logic                               rd_last,
    output logic [compute_pkg::dest_width-1:0] rd_dest
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    logic [width-1:0]                   mem_data [depth];
    logic                               mem_last [depth];
    logic [compute_pkg::dest_width-1:0] mem_dest [depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic                 do_wr;
    logic                 do_rd;

    assign wr_ready = (count != cnt_width'(depth));
    assign rd_valid = (count != '0);
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    // output shows the oldest entry directly
    assign rd_data = mem_data[rd_ptr];
    assign rd_last = mem_last[rd_ptr];
    assign rd_dest = mem_dest[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
            mem_dest[wr_ptr] <= wr_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/ingress_steer.sv
`timescale 1ns/1ps

module ingress_steer #(
    parameter int data_width   = compute_pkg::data_width,
    parameter int max_buffered = 2
) (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   in_q,
    input  logic in_user,
    input  logic buf_pkt_done,
    pkt_if.src   buf_in,
    pkt_if.src   detour_s,
    output logic credit_sub
);

    localparam int cnt_width = $clog2(max_buffered + 1);

    compute_pkg::steer_state_t state;

    logic [cnt_width-1:0]               buf_count;
    logic [compute_pkg::dest_width-1:0] detour_dest;
    logic                               in_fire;
    logic                               ins_done;

    assign in_fire  = in_q.valid && in_q.ready;
    assign ins_done = (state == compute_pkg::steer_insert) && in_fire && in_q.last;

    // inserted packets whose user bit is clear hand back a credit
    assign credit_sub = ins_done && !in_user;

    // payload goes to both sinks, valid selects the live one
    assign buf_in.data   = in_q.data[data_width-1:0];
    assign buf_in.last   = in_q.last;
    assign buf_in.dest   = in_q.dest;
    assign buf_in.valid  = (state == compute_pkg::steer_insert) && in_q.valid;

    assign detour_s.data  = in_q.data[data_width-1:0];
    assign detour_s.last  = in_q.last;
    assign detour_s.dest  = detour_dest;
    assign detour_s.valid = (state == compute_pkg::steer_detour) && in_q.valid;

    always_comb begin
        case (state)
            compute_pkg::steer_insert: in_q.ready = buf_in.ready;
            compute_pkg::steer_detour: in_q.ready = detour_s.ready;
            default:                   in_q.ready = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= compute_pkg::steer_idle;
        end else begin
            case (state)
                compute_pkg::steer_idle: begin
                    if (in_q.valid) begin
                        if (buf_count < cnt_width'(max_buffered)) begin
                            state <= compute_pkg::steer_insert;
                        end else begin
                            state <= compute_pkg::steer_detour;
                        end
                    end
                end
                default: begin
                    if (in_fire && in_q.last) begin
                        state <= compute_pkg::steer_idle;
                    end
                end
            endcase
        end
    end

    // detour target picked by the descriptor port bit
    always_ff @(posedge clk) begin
        if (state == compute_pkg::steer_idle && in_q.valid) begin
            detour_dest <= in_q.data[compute_pkg::port_of] ?
                           compute_pkg::detour_dest_1 : compute_pkg::detour_dest_0;
        end
    end

    // whole packets sitting in the data buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_count <= '0;
        end else if (ins_done && !buf_pkt_done) begin
            buf_count <= buf_count + 1'b1;
        end else if (buf_pkt_done && !ins_done) begin
            buf_count <= buf_count - 1'b1;
        end
    end

endmodule

// File: rtl/compute_stage.sv
`timescale 1ns/1ps

module compute_stage #(
    parameter int data_width = compute_pkg::data_width
) (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   buf_out,
    pkt_if.src   comp_s,
    output logic buf_pkt_done,
    output logic credit_add
);

    compute_pkg::compute_state_t state;

    logic [compute_pkg::time_size-1:0]  countdown;
    logic [compute_pkg::time_size-1:0]  head_time;
    logic [compute_pkg::dest_width-1:0] data_dest;
    logic [compute_pkg::dest_width-1:0] next_item;
    logic [compute_pkg::dest_width-1:0] next_dest;
    logic [data_width-1:0]              head_word;
    logic                               sending;
    logic                               out_fire;
    logic                               pkt_end;

    assign head_time = buf_out.data[compute_pkg::time_of +: compute_pkg::time_size];

    // drop the current hop from the chain
    always_comb begin
        head_word = buf_out.data;
        head_word[compute_pkg::chain_of +: compute_pkg::chain_size] =
            buf_out.data[compute_pkg::chain_of +: compute_pkg::chain_size]
            >> compute_pkg::dest_width;
    end

    // empty chain slot means the packet returns to dma
    assign next_item = head_word[compute_pkg::chain_of +: compute_pkg::dest_width];
    assign next_dest = (next_item == '0) ? compute_pkg::dma_dest : next_item;

    assign sending  = (state == compute_pkg::comp_head) || (state == compute_pkg::comp_data);
    assign out_fire = comp_s.valid && comp_s.ready;
    assign pkt_end  = out_fire && buf_out.last;

    assign comp_s.valid  = sending && buf_out.valid;
    assign comp_s.last   = buf_out.last;
    assign comp_s.data   = (state == compute_pkg::comp_head) ? head_word : buf_out.data;
    assign comp_s.dest   = (state == compute_pkg::comp_head) ? next_dest : data_dest;
    assign buf_out.ready = sending && comp_s.ready;

    assign buf_pkt_done = pkt_end;
    assign credit_add   = pkt_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= compute_pkg::comp_idle;
            countdown <= '0;
        end else begin
            case (state)
                compute_pkg::comp_idle: begin
                    if (buf_out.valid) begin
                        countdown <= head_time;
                        if (head_time == '0) begin
                            state <= compute_pkg::comp_head;
                        end else begin
                            state <= compute_pkg::comp_busy;
                        end
                    end
                end
                compute_pkg::comp_busy: begin
                    // one cycle per unit of processing time
                    if (countdown == 1) begin
                        state <= compute_pkg::comp_head;
                    end
                    countdown <= countdown - 1'b1;
                end
                compute_pkg::comp_head: begin
                    if (out_fire) begin
                        state <= buf_out.last ? compute_pkg::comp_idle : compute_pkg::comp_data;
                    end
                end
                default: begin
                    if (pkt_end) begin
                        state <= compute_pkg::comp_idle;
                    end
                end
            endcase
        end
    end

    // body words follow the head's destination
    always_ff @(posedge clk) begin
        if (state == compute_pkg::comp_head && out_fire) begin
            data_dest <= next_dest;
        end
    end

endmodule

// File: rtl/egress_arbiter.sv
`timescale 1ns/1ps

module egress_arbiter (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   detour_s,
    pkt_if.snk   comp_s,
    pkt_if.src   out_s
);

    // sel 0 picks the detour stream, 1 the compute stream
    logic locked;
    logic grant;
    logic prio;
    logic sel;
    logic out_fire;

    always_comb begin
        if (locked) begin
            sel = grant;
        end else if (detour_s.valid && comp_s.valid) begin
            sel = prio;
        end else begin
            sel = comp_s.valid;
        end
    end

    assign out_s.valid = sel ? comp_s.valid : detour_s.valid;
    assign out_s.data  = sel ? comp_s.data  : detour_s.data;
    assign out_s.last  = sel ? comp_s.last  : detour_s.last;
    assign out_s.dest  = sel ? comp_s.dest  : detour_s.dest;

    assign detour_s.ready = !sel && out_s.ready;
    assign comp_s.ready   = sel && out_s.ready;

    assign out_fire = out_s.valid && out_s.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            grant  <= 1'b0;
            prio   <= 1'b0;
        end else if (out_fire) begin
            if (out_s.last) begin
                // packet done, other side goes first next time
                locked <= 1'b0;
                prio   <= !sel;
            end else begin
                locked <= 1'b1;
                grant  <= sel;
            end
        end
    end

endmodule

// File: rtl/compute_engine.sv
`timescale 1ns/1ps

module compute_engine #(
    parameter int data_width   = compute_pkg::data_width,
    parameter int max_buffered = 2,
    parameter int in_depth     = 8,
    parameter int buffer_depth = 64,
    parameter int out_depth    = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [data_width-1:0]              s_data,
    input  logic                               s_valid,
    output logic                               s_ready,
    input  logic                               s_last,
    input  logic [compute_pkg::dest_width-1:0] s_dest,
    input  logic                               s_user,
    output logic [data_width-1:0]              m_data,
    output logic                               m_valid,
    input  logic                               m_ready,
    output logic                               m_last,
    output logic [compute_pkg::dest_width-1:0] m_dest,
    output logic                               credit_add,
    output logic                               credit_sub
);

    pkt_if #(.data_width(data_width)) in_q ();
    pkt_if #(.data_width(data_width)) buf_in ();
    pkt_if #(.data_width(data_width)) buf_out ();
    pkt_if #(.data_width(data_width)) detour_s ();
    pkt_if #(.data_width(data_width)) comp_s ();
    pkt_if #(.data_width(data_width)) out_s ();

    // user bit rides on top of the data word through the input FIFO
    logic [data_width:0] in_word;
    logic                in_user;
    logic                buf_pkt_done;

    assign in_q.data = in_word[data_width-1:0];
    assign in_user   = in_word[data_width];

    pkt_fifo #(.width(data_width + 1), .depth(in_depth)) input_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  ({s_user, s_data}),
        .wr_valid (s_valid),
        .wr_ready (s_ready),
        .wr_last  (s_last),
        .wr_dest  (s_dest),
        .rd_data  (in_word),
        .rd_valid (in_q.valid),
        .rd_ready (in_q.ready),
        .rd_last  (in_q.last),
        .rd_dest  (in_q.dest)
    );

    ingress_steer #(.data_width(data_width), .max_buffered(max_buffered)) steer (
        .clk          (clk),
        .rst          (rst),
        .in_q         (in_q),
        .in_user      (in_user),
        .buf_pkt_done (buf_pkt_done),
        .buf_in       (buf_in),
        .detour_s     (detour_s),
        .credit_sub   (credit_sub)
    );

    pkt_fifo #(.width(data_width), .depth(buffer_depth)) buffer_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (buf_in.data),
        .wr_valid (buf_in.valid),
        .wr_ready (buf_in.ready),
        .wr_last  (buf_in.last),
        .wr_dest  (buf_in.dest),
        .rd_data  (buf_out.data),
        .rd_valid (buf_out.valid),
        .rd_ready (buf_out.ready),
        .rd_last  (buf_out.last),
        .rd_dest  (buf_out.dest)
    );

    compute_stage #(.data_width(data_width)) compute (
        .clk          (clk),
        .rst          (rst),
        .buf_out      (buf_out),
        .comp_s       (comp_s),
        .buf_pkt_done (buf_pkt_done),
        .credit_add   (credit_add)
    );

    egress_arbiter arbiter (
        .clk      (clk),
        .rst      (rst),
        .detour_s (detour_s),
        .comp_s   (comp_s),
        .out_s    (out_s)
    );

    pkt_fifo #(.width(data_width), .depth(out_depth)) output_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (out_s.data),
        .wr_valid (out_s.valid),
        .wr_ready (out_s.ready),
        .wr_last  (out_s.last),
        .wr_dest  (out_s.dest),
        .rd_data  (m_data),
        .rd_valid (m_valid),
        .rd_ready (m_ready),
        .rd_last  (m_last),
        .rd_dest  (m_dest)
    );

endmodule

// File: testbench/tb_compute_engine.sv
`timescale 1ns/1ps

module tb_compute_engine;

    localparam int num_rows   = 13;
    localparam int num_phases = 5;
    localparam int max_words  = 8;
    localparam int dw         = compute_pkg::data_width;

    logic                               clk;
    logic                               rst;
    logic [dw-1:0]                      s_data;
    logic                               s_valid;
    logic                               s_ready;
    logic                               s_last;
    logic [compute_pkg::dest_width-1:0] s_dest;
    logic                               s_user;
    logic [dw-1:0]                      m_data;
    logic                               m_valid;
    logic                               m_ready;
    logic                               m_last;
    logic [compute_pkg::dest_width-1:0] m_dest;
    logic                               credit_add;
    logic                               credit_sub;

    // stimulus table, one entry per packet
    int                                 row_phase [num_rows];
    logic [compute_pkg::tag_size-1:0]   row_tag [num_rows];
    logic                               row_port [num_rows];
    int                                 row_time [num_rows];
    logic [compute_pkg::chain_size-1:0] row_chain [num_rows];
    int                                 row_words [num_rows];
    logic                               row_user [num_rows];
    logic                               row_insert [num_rows];
    logic [compute_pkg::dest_width-1:0] row_dest [num_rows];
    int                                 row_count = 0;

    logic [dw-1:0] pkt_words [num_rows][max_words];
    logic [dw-1:0] exp_head [num_rows];
    logic          received [num_rows];

    int value_errors   = 0;
    int packet_errors  = 0;
    int timeout_errors = 0;
    int recv_count     = 0;
    int add_count      = 0;
    int sub_count      = 0;
    int cycle_count    = 0;
    int cycle_limit    = 0;
    int cur_row        = -1;
    int word_idx       = 0;
    logic in_pkt       = 1'b0;
    logic stall_mode   = 1'b0;

    compute_engine compute_engine_i (
        .clk        (clk),
        .rst        (rst),
        .s_data     (s_data),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_last     (s_last),
        .s_dest     (s_dest),
        .s_user     (s_user),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_last     (m_last),
        .m_dest     (m_dest),
        .credit_add (credit_add),
        .credit_sub (credit_sub)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] time %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: value=%0d packet=%0d timeout=%0d",
                 value_errors, packet_errors, timeout_errors);
        if (value_errors + packet_errors + timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic set_row(input int phase, input int tag, input int port, input int ptime,
                           input int c0, input int c1, input int c2, input int c3,
                           input int words, input int user, input int insert, input int dest);
        row_phase[row_count]  = phase;
        row_tag[row_count]    = 8'(tag);
        row_port[row_count]   = 1'(port);
        row_time[row_count]   = ptime;
        row_chain[row_count]  = {3'(c3), 3'(c2), 3'(c1), 3'(c0)};
        row_words[row_count]  = words;
        row_user[row_count]   = 1'(user);
        row_insert[row_count] = 1'(insert);
        row_dest[row_count]   = 3'(dest);
        row_count++;
    endtask

    // descriptor in word 0, random payload behind it
    task automatic make_packets();
        for (int r = 0; r < num_rows; r++) begin
            for (int w = 0; w < max_words; w++) begin
                pkt_words[r][w] = {$urandom, $urandom};
            end
            pkt_words[r][0][compute_pkg::time_of +: compute_pkg::time_size] = 16'(row_time[r]);
            pkt_words[r][0][compute_pkg::chain_of +: compute_pkg::chain_size] = row_chain[r];
            pkt_words[r][0][compute_pkg::port_of] = row_port[r];
            pkt_words[r][0][compute_pkg::tag_of +: compute_pkg::tag_size] = row_tag[r];
            exp_head[r] = pkt_words[r][0];
            // a computed packet leaves with its chain one hop shorter
            if (row_insert[r]) begin
                exp_head[r][compute_pkg::chain_of +: compute_pkg::chain_size] =
                    row_chain[r] >> compute_pkg::dest_width;
            end
            received[r] = 1'b0;
        end
    endtask

    task automatic send_word(input logic [dw-1:0] data, input logic last, input logic user);
        s_data  <= data;
        s_valid <= 1'b1;
        s_last  <= last;
        s_user  <= user;
        s_dest  <= '0;
        @(negedge clk);
        while (!s_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic take_word();
        logic [compute_pkg::tag_size-1:0] tag;
        if (!in_pkt) begin
            tag = m_data[compute_pkg::tag_of +: compute_pkg::tag_size];
            cur_row = -1;
            for (int r = 0; r < num_rows; r++) begin
                if (row_tag[r] == tag) begin
                    cur_row = r;
                end
            end
            if (cur_row < 0) begin
                $display("unknown packet with tag 0x%0h at time %0t", tag, $time);
                packet_errors++;
            end else if (received[cur_row]) begin
                $display("packet with tag 0x%0h arrived twice", tag);
                packet_errors++;
                cur_row = -1;
            end
            word_idx = 0;
            in_pkt   = 1'b1;
        end
        if (cur_row >= 0) begin
            if (word_idx < row_words[cur_row]) begin
                check_value("m_data",
                            (word_idx == 0) ? exp_head[cur_row] : pkt_words[cur_row][word_idx],
                            m_data);
                check_value("m_dest", 64'(row_dest[cur_row]), 64'(m_dest));
                check_value("m_last", 64'(word_idx == row_words[cur_row] - 1), 64'(m_last));
            end else begin
                $display("packet with tag 0x%0h has too many words", row_tag[cur_row]);
                packet_errors++;
            end
        end
        word_idx++;
        if (m_last) begin
            if (cur_row >= 0) begin
                received[cur_row] = 1'b1;
                recv_count++;
            end
            in_pkt = 1'b0;
        end
    endtask

    // outputs and credit pulses are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (credit_add) begin
                add_count++;
            end
            if (credit_sub) begin
                sub_count++;
            end
            if (m_valid && m_ready) begin
                take_word();
            end
        end
    end

    always @(posedge clk) begin
        if (stall_mode) begin
            m_ready <= ($urandom % 4) != 0;
        end else begin
            m_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d packets received",
                     cycle_count, recv_count, num_rows);
            timeout_errors++;
            finish_run();
        end
    end

    initial begin
        int seed_val;
        int expected_total;
        int exp_add;
        int exp_sub;
        rst     = 1'b1;
        s_data  = '0;
        s_valid = 1'b0;
        s_last  = 1'b0;
        s_dest  = '0;
        s_user  = 1'b0;
        m_ready = 1'b1;
        seed_val = $urandom(32'h1bca7e4d);
        expected_total = 0;
        exp_add = 0;
        exp_sub = 0;

        // phase tag port time chain0..3 words user insert dest
        set_row(0, 'h11, 0,   5, 2, 5, 6, 0, 3, 0, 1, 5);
        set_row(1, 'h12, 1,   0, 4, 7, 0, 0, 1, 1, 1, 7);
        // next chain item empty, back to dma
        set_row(2, 'h13, 0,  12, 6, 0, 3, 0, 4, 0, 1, 1);
        // back to back burst, buffer limit reached after two
        set_row(3, 'h21, 0, 300, 3, 2, 0, 0, 3, 0, 1, 2);
        set_row(3, 'h22, 1, 300, 5, 0, 0, 0, 2, 1, 1, 1);
        set_row(3, 'h23, 0, 300, 2, 4, 0, 0, 3, 0, 0, 0);
        set_row(3, 'h24, 1, 300, 7, 6, 0, 0, 2, 0, 0, 3);
        // mixed traffic while the output stalls
        set_row(4, 'h31, 0, 150, 1, 3, 5, 0, 5, 0, 1, 3);
        set_row(4, 'h32, 1,  20, 2, 6, 0, 0, 3, 1, 1, 6);
        set_row(4, 'h33, 1,   9, 0, 0, 0, 0, 4, 0, 0, 3);
        set_row(4, 'h34, 0,   0, 4, 4, 0, 0, 2, 1, 0, 0);
        set_row(4, 'h35, 1,  40, 3, 1, 2, 0, 6, 0, 0, 3);
        set_row(4, 'h36, 0,   0, 5, 0, 0, 0, 1, 0, 0, 0);
        make_packets();

        for (int r = 0; r < num_rows; r++) begin
            cycle_limit += (row_words[r] + row_time[r] + 30) * 4;
            exp_add += row_insert[r] ? 1 : 0;
            exp_sub += (row_insert[r] && !row_user[r]) ? 1 : 0;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // idle outputs right after reset
        @(negedge clk);
        check_value("s_ready", 64'(1'b1), 64'(s_ready));
        check_value("m_valid", 64'(1'b0), 64'(m_valid));
        check_value("credit_add", 64'(1'b0), 64'(credit_add));
        check_value("credit_sub", 64'(1'b0), 64'(credit_sub));
        @(posedge clk);

        for (int p = 0; p < num_phases; p++) begin
            stall_mode <= (p == num_phases - 1);
            for (int r = 0; r < num_rows; r++) begin
                if (row_phase[r] == p) begin
                    for (int w = 0; w < row_words[r]; w++) begin
                        send_word(pkt_words[r][w], w == row_words[r] - 1, row_user[r]);
                    end
                    expected_total++;
                end
            end
            s_valid <= 1'b0;
            s_last  <= 1'b0;
            while (recv_count < expected_total) begin
                @(posedge clk);
            end
        end

        stall_mode <= 1'b0;
        repeat (20) @(posedge clk);
        check_value("credit_add pulses", 64'(exp_add), 64'(add_count));
        check_value("credit_sub pulses", 64'(exp_sub), 64'(sub_count));
        for (int r = 0; r < num_rows; r++) begin
            if (!received[r]) begin
                $display("packet with tag 0x%0h never arrived", row_tag[r]);
                packet_errors++;
            end
        end
        finish_run();
    end

endmodule

// File: filelist.f
rtl/compute_pkg.sv
rtl/pkt_if.sv
rtl/pkt_fifo.sv
rtl/ingress_steer.sv
rtl/compute_stage.sv
rtl/egress_arbiter.sv
rtl/compute_engine.sv
testbench/tb_compute_engine.sv

// File: run_sim.sh
#!/bin/sh
# build and run the compute_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_compute_engine \
    -f filelist.f \
    -o tb_compute_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_compute_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1
